/* run.sh */
#!/bin/sh
# Build and run the blitter simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_blit -o tb_blit
./obj_dir/tb_blit | tee sim.log
if grep -q "Verification failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

/* sim/blit_model.svh */
// Blitter reference model
`ifndef BLIT_MODEL_SVH
`define BLIT_MODEL_SVH

	// Expected memory contents, kept in step with every write
	phrase_t shadow [MEM_SIZE];

	// Byte-enabled write into the shadow memory
	function automatic void shadow_write(input int addr, input phrase_t data,
			input byte_mask_t be);
		for (int b = 0; b < 8; b++) begin
			if (be[b]) begin
				shadow[addr][8*b +: 8] = data[8*b +: 8];
			end
		end
	endfunction

	// Bytes the blitter writes for one source phrase
	function automatic byte_mask_t expected_enables(input phrase_t src, input pix_size_t pix,
			input logic dcompen, input logic bcompen, input logic [7:0] pattern);
		byte_mask_t en;
		logic lo_hit;
		logic hi_hit;
		// Monochrome expansion takes its enables from the low source byte
		en = bcompen ? src[7:0] : 8'hff;
		// 8 bpp, each byte is a pixel of its own
		if (dcompen && (pix == 3'd3)) begin
			for (int b = 0; b < 8; b++) begin
				if (src[8*b +: 8] == pattern) begin
					en[b] = 1'b0;
				end
			end
		end
		// 16 bpp, four pixels per phrase
		if (dcompen && (pix == 3'd4)) begin
			for (int p = 0; p < 4; p++) begin
				lo_hit = (src[16*p +: 8] == pattern);
				hi_hit = (src[16*p + 8 +: 8] == pattern);
				if (lo_hit && hi_hit) begin
					en[2*p] = 1'b0;
					en[2*p + 1] = 1'b0;
				end
			end
		end
		return en;
	endfunction

	// Replays one blit on the shadow memory
	function automatic void model_blit(input int src, input int dst, input int cnt,
			input pix_size_t pix, input logic dcompen, input logic bcompen,
			input logic [7:0] pattern, input phrase_t fg);
		phrase_t s;
		byte_mask_t en;
		for (int i = 0; i < cnt; i++) begin
			s = shadow[src + i];
			en = expected_enables(s, pix, dcompen, bcompen, pattern);
			// Foreground colour replaces the source in bit compare mode
			shadow_write(dst + i, bcompen ? fg : s, en);
		end
	endfunction

`endif

/* sim/tb_blit.sv */
// Blitter testbench
module tb_blit import blit_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_W = 10;
	localparam int CNT_W = 8;
	localparam int BUF_DEPTH = 2;
	localparam int MEM_SIZE = 2 ** ADDR_W;
	// Sources below DST_LOW, destinations at or above it
	localparam int DST_LOW = MEM_SIZE / 2;
	localparam int MAX_CNT = 20;
	localparam int NUM_TESTS = 24;
	localparam int B2B_CMDS = 4;
	localparam int CLK_PERIOD = 40;
	// Memory fill and full readback, then worst case per command
	localparam int WATCH_CYCLES = 4 * MEM_SIZE
		+ (NUM_TESTS + B2B_CMDS) * (MAX_CNT * 16 + 64) + 200;

	logic sys_clk = 1'b0;
	logic rst_n;
	logic cmd_start;
	logic [ADDR_W-1:0] cmd_src;
	logic [ADDR_W-1:0] cmd_dst;
	logic [CNT_W-1:0] cmd_count;
	pix_size_t cmd_pixsize;
	logic cmd_dcompen;
	logic cmd_bcompen;
	logic [7:0] cmd_pattern;
	phrase_t cmd_fgcolor;
	logic host_req;
	logic host_we;
	logic [ADDR_W-1:0] host_addr;
	phrase_t host_wdata;
	byte_mask_t host_be;
	logic host_gnt;
	phrase_t host_rdata;
	logic host_rvalid;
	logic busy;
	logic done;

	// Command of the current test
	int cur_src;
	int cur_dst;
	int cur_cnt;
	pix_size_t cur_pix;
	logic cur_dcomp;
	logic cur_bcomp;
	logic [7:0] cur_pat;
	phrase_t cur_fg;
	integer seed;
	int errors;
	string mode_name [4] = '{"normal", "dcomp8", "dcomp16", "bcomp"};
	int b2b_cnt [B2B_CMDS] = '{9, 0, MAX_CNT, 5};

	`include "blit_model.svh"

	blit_top #(.ADDR_W(ADDR_W), .CNT_W(CNT_W), .BUF_DEPTH(BUF_DEPTH)) DUT (
		.sys_clk(sys_clk), .rst_n(rst_n), .cmd_start(cmd_start),
		.cmd_src(cmd_src), .cmd_dst(cmd_dst), .cmd_count(cmd_count),
		.cmd_pixsize(cmd_pixsize), .cmd_dcompen(cmd_dcompen), .cmd_bcompen(cmd_bcompen),
		.cmd_pattern(cmd_pattern), .cmd_fgcolor(cmd_fgcolor),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_be(host_be), .host_gnt(host_gnt),
		.host_rdata(host_rdata), .host_rvalid(host_rvalid), .busy(busy), .done(done)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// Watchdog
	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("Error: watchdog expired, the tests did not complete in time");
		$display("Verification failed");
		$finish;
	end

	// Non-negative random value below n
	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % n;
	endfunction

	// Source phrase with about half its bytes equal to the pattern
	function automatic phrase_t biased_phrase(input logic [7:0] pat);
		phrase_t p;
		for (int b = 0; b < 8; b++) begin
			if (rand_below(2) == 0) begin
				p[8*b +: 8] = pat;
			end else begin
				p[8*b +: 8] = 8'($random(seed));
			end
		end
		return p;
	endfunction

	// Random command for one compare mode, ranges kept apart
	function automatic void set_command(input int mode, input int cnt);
		cur_src = rand_below(DST_LOW - MAX_CNT);
		cur_dst = DST_LOW + rand_below(MEM_SIZE - DST_LOW - MAX_CNT - 1);
		cur_cnt = cnt;
		cur_pat = 8'($random(seed));
		cur_fg = {$random(seed), $random(seed)};
		cur_pix = ((mode == 2) || ((mode == 0) && (rand_below(2) == 0))) ? 3'd4 : 3'd3;
		cur_dcomp = (mode == 1) || (mode == 2);
		cur_bcomp = (mode == 3);
	endfunction

	// Samples just after the falling edge, where the grant is settled
	task automatic wait_host_grant();
		#1;
		while (!host_gnt) begin
			@(negedge sys_clk);
			#1;
		end
	endtask

	// All host tasks start and end on a falling edge
	task automatic host_write(input int addr, input phrase_t data, input byte_mask_t be);
		host_req = 1'b1;
		host_we = 1'b1;
		host_addr = ADDR_W'(addr);
		host_wdata = data;
		host_be = be;
		wait_host_grant();
		@(negedge sys_clk);
		host_req = 1'b0;
		host_we = 1'b0;
		shadow_write(addr, data, be);
	endtask

	task automatic host_read(input int addr, output phrase_t data);
		host_req = 1'b1;
		host_we = 1'b0;
		host_addr = ADDR_W'(addr);
		wait_host_grant();
		@(negedge sys_clk);
		host_req = 1'b0;
		// Data is due one cycle after the grant
		if (!host_rvalid) begin
			$display("Error: host read of address %0d returned no valid data", addr);
			errors++;
		end
		data = host_rdata;
	endtask

	task automatic check_range(input string name, input int base, input int n);
		phrase_t got;
		for (int i = 0; i < n; i++) begin
			host_read(base + i, got);
			if (got !== shadow[base + i]) begin
				$display("Error: %s address %0d expected %h actual %h",
					name, base + i, shadow[base + i], got);
				errors++;
			end
		end
	endtask

	// Issues the current command and follows busy and done
	task automatic run_blit(input string name);
		if (busy) begin
			$display("Error: %s found the blitter busy before its start", name);
			errors++;
		end
		cmd_start = 1'b1;
		cmd_src = ADDR_W'(cur_src);
		cmd_dst = ADDR_W'(cur_dst);
		cmd_count = CNT_W'(cur_cnt);
		cmd_pixsize = cur_pix;
		cmd_dcompen = cur_dcomp;
		cmd_bcompen = cur_bcomp;
		cmd_pattern = cur_pat;
		cmd_fgcolor = cur_fg;
		@(negedge sys_clk);
		cmd_start = 1'b0;
		// Busy holds up to the done cycle
		while (!done) begin
			if (!busy) begin
				$display("Error: %s dropped busy before done", name);
				errors++;
			end
			@(negedge sys_clk);
		end
		if (busy) begin
			$display("Error: %s still busy in the done cycle", name);
			errors++;
		end
		@(negedge sys_clk);
		if (done) begin
			$display("Error: %s done pulse lasted more than one cycle", name);
			errors++;
		end
		model_blit(cur_src, cur_dst, cur_cnt, cur_pix, cur_dcomp, cur_bcomp, cur_pat, cur_fg);
	endtask

	initial begin
		int mode;
		int cnt;
		int addr;
		byte_mask_t be;
		seed = 55133;
		errors = 0;
		rst_n = 1'b0;
		cmd_start = 1'b0;
		cmd_src = '0;
		cmd_dst = '0;
		cmd_count = '0;
		cmd_pixsize = 3'd3;
		cmd_dcompen = 1'b0;
		cmd_bcompen = 1'b0;
		cmd_pattern = '0;
		cmd_fgcolor = '0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_be = '0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;
		if (busy || done || host_gnt || host_rvalid) begin
			$display("Error: outputs not low after reset");
			errors++;
		end

		// Whole memory gets random phrases
		for (int a = 0; a < MEM_SIZE; a++) begin
			host_write(a, {$random(seed), $random(seed)}, 8'hff);
		end

		// Host round trips with partial byte enables
		for (int k = 0; k < 16; k++) begin
			addr = rand_below(MEM_SIZE);
			be = 8'($random(seed));
			host_write(addr, {$random(seed), $random(seed)}, be);
			check_range("host_rw", addr, 1);
		end

		// One blit per test, modes in turn
		for (int t = 0; t < NUM_TESTS; t++) begin
			mode = t % 4;
			cnt = (t == 6) ? 0 : BUF_DEPTH + 1 + rand_below(MAX_CNT - BUF_DEPTH);
			set_command(mode, cnt);
			for (int i = 0; i < cnt; i++) begin
				host_write(cur_src + i, biased_phrase(cur_pat), 8'hff);
			end
			run_blit(mode_name[mode]);
			// The phrase past the end stays untouched
			check_range(mode_name[mode], cur_dst, cnt + 1);
		end

		// Commands back to back, no host traffic between them
		for (int c = 0; c < B2B_CMDS; c++) begin
			set_command(rand_below(4), b2b_cnt[c]);
			run_blit("back_to_back");
		end
		check_range("final_mem", 0, MEM_SIZE);

		$display("Test run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* source/blit_ctrl.sv */
// Blit command sequencer
module blit_ctrl import blit_pkg::*; #(
	parameter int ADDR_W = 10,
	parameter int CNT_W = 8
) (
	input logic sys_clk,
	input logic rst_n,
	input logic cmd_start,
	input logic [ADDR_W-1:0] cmd_src,
	input logic [ADDR_W-1:0] cmd_dst,
	input logic [CNT_W-1:0] cmd_count,
	input pix_size_t cmd_pixsize,
	input logic cmd_dcompen,
	input logic cmd_bcompen,
	input logic [7:0] cmd_pattern,
	input phrase_t cmd_fgcolor,
	input logic wr_done,
	output logic busy,
	output logic done,
	output logic run,
	output logic [ADDR_W-1:0] src_base,
	output logic [ADDR_W-1:0] dst_base,
	output logic [CNT_W-1:0] count,
	output pix_size_t pixsize,
	output logic dcompen,
	output logic bcompen,
	output logic [7:0] pattern,
	output phrase_t fgcolor
);

	blit_state_t state;
	logic [CNT_W-1:0] wr_cnt;
	logic accept;
	logic last_wr;

	// A start is taken in idle and in finish
	assign accept = cmd_start && (state != state_run);
	// Write that completes the run
	assign last_wr = wr_done && ((wr_cnt + CNT_W'(1)) == count);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= state_idle;
			wr_cnt <= '0;
		end else begin
			case (state)
				state_run: begin
					if (wr_done) begin
						wr_cnt <= wr_cnt + CNT_W'(1);
					end
					if (last_wr) begin
						state <= state_finish;
					end
				end
				default: begin
					wr_cnt <= '0;
					if (accept) begin
						// Zero count has nothing to write
						state <= (cmd_count == '0) ? state_finish : state_run;
					end else begin
						state <= state_idle;
					end
				end
			endcase
		end
	end

	// Command registers load on accept
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			src_base <= cmd_src;
			dst_base <= cmd_dst;
			count <= cmd_count;
			pixsize <= cmd_pixsize;
			dcompen <= cmd_dcompen;
			bcompen <= cmd_bcompen;
			pattern <= cmd_pattern;
			fgcolor <= cmd_fgcolor;
		end
	end

	// Run enables fetch and writer
	assign run = (state == state_run);
	// Busy drops in the done cycle
	assign busy = run;
	assign done = (state == state_finish);

endmodule

/* source/blit_pkg.sv */
// Blitter shared types
package blit_pkg;

	// One memory phrase
	typedef logic [63:0] phrase_t;
	// One flag per byte of a phrase
	typedef logic [7:0] byte_mask_t;
	// Pixel size code
	typedef logic [2:0] pix_size_t;
	// Memory requester index
	typedef logic [1:0] arb_sel_t;

	// Pixel size codes handled by the compare logic
	localparam pix_size_t PIX_8BPP = 3'd3;
	localparam pix_size_t PIX_16BPP = 3'd4;

	// Requester indices, also the round-robin order
	localparam arb_sel_t SEL_FETCH = 2'd0;
	localparam arb_sel_t SEL_WRITER = 2'd1;
	localparam arb_sel_t SEL_HOST = 2'd2;

	// Blit sequencer states
	typedef enum logic [1:0] {
		state_idle,
		state_run,
		state_finish
	} blit_state_t;

endpackage

/* source/blit_top.sv */
// Phrase blitter top level
module blit_top import blit_pkg::*; #(
	parameter int ADDR_W = 10,
	parameter int CNT_W = 8,
	parameter int BUF_DEPTH = 2
) (
	input logic sys_clk,
	input logic rst_n,
	input logic cmd_start,
	input logic [ADDR_W-1:0] cmd_src,
	input logic [ADDR_W-1:0] cmd_dst,
	input logic [CNT_W-1:0] cmd_count,
	input pix_size_t cmd_pixsize,
	input logic cmd_dcompen,
	input logic cmd_bcompen,
	input logic [7:0] cmd_pattern,
	input phrase_t cmd_fgcolor,
	input logic host_req,
	input logic host_we,
	input logic [ADDR_W-1:0] host_addr,
	input phrase_t host_wdata,
	input byte_mask_t host_be,
	output logic host_gnt,
	output phrase_t host_rdata,
	output logic host_rvalid,
	output logic busy,
	output logic done
);

	// Latched command
	logic run;
	logic [ADDR_W-1:0] src_base;
	logic [ADDR_W-1:0] dst_base;
	logic [CNT_W-1:0] count;
	pix_size_t pixsize;
	logic dcompen;
	logic bcompen;
	logic [7:0] pattern;
	phrase_t fgcolor;
	// Fetch side
	logic fetch_req;
	logic [ADDR_W-1:0] fetch_addr;
	logic fetch_gnt;
	logic fetch_rvalid;
	phrase_t rdata;
	logic credit_ret;
	// Compare pipeline
	logic dc_valid;
	phrase_t dc_data;
	byte_mask_t dcomp;
	logic cc_valid;
	phrase_t cc_data;
	byte_mask_t dbinh_n;
	// Writer side
	logic wr_req;
	logic [ADDR_W-1:0] wr_addr;
	phrase_t wr_wdata;
	byte_mask_t wr_be;
	logic wr_gnt;
	logic wr_done;
	// Memory port
	logic mem_en;
	logic mem_we;
	logic [ADDR_W-1:0] mem_addr;
	phrase_t mem_wdata;
	byte_mask_t mem_be;
	phrase_t mem_rdata;

	blit_ctrl #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) u_ctrl (
		.sys_clk(sys_clk), .rst_n(rst_n), .cmd_start(cmd_start),
		.cmd_src(cmd_src), .cmd_dst(cmd_dst), .cmd_count(cmd_count),
		.cmd_pixsize(cmd_pixsize), .cmd_dcompen(cmd_dcompen), .cmd_bcompen(cmd_bcompen),
		.cmd_pattern(cmd_pattern), .cmd_fgcolor(cmd_fgcolor), .wr_done(wr_done),
		.busy(busy), .done(done), .run(run), .src_base(src_base), .dst_base(dst_base),
		.count(count), .pixsize(pixsize), .dcompen(dcompen), .bcompen(bcompen),
		.pattern(pattern), .fgcolor(fgcolor)
	);

	src_fetch #(.ADDR_W(ADDR_W), .CNT_W(CNT_W), .BUF_DEPTH(BUF_DEPTH)) u_fetch (
		.sys_clk(sys_clk), .rst_n(rst_n), .run(run), .src_base(src_base), .count(count),
		.credit_ret(credit_ret), .gnt(fetch_gnt), .req(fetch_req), .addr(fetch_addr)
	);

	data_compare u_dcmp (
		.sys_clk(sys_clk), .rst_n(rst_n), .in_valid(fetch_rvalid), .in_data(rdata),
		.pattern(pattern), .out_valid(dc_valid), .out_data(dc_data), .dcomp(dcomp)
	);

	comp_ctrl u_comp (
		.sys_clk(sys_clk), .rst_n(rst_n), .in_valid(dc_valid), .in_data(dc_data),
		.dcomp(dcomp), .pixsize(pixsize), .dcompen(dcompen), .bcompen(bcompen),
		.fgcolor(fgcolor), .out_valid(cc_valid), .out_data(cc_data), .dbinh_n(dbinh_n)
	);

	dst_writer #(.ADDR_W(ADDR_W), .BUF_DEPTH(BUF_DEPTH)) u_writer (
		.sys_clk(sys_clk), .rst_n(rst_n), .run(run), .dst_base(dst_base),
		.in_valid(cc_valid), .in_data(cc_data), .dbinh_n(dbinh_n), .gnt(wr_gnt),
		.req(wr_req), .addr(wr_addr), .wdata(wr_wdata), .be(wr_be),
		.credit_ret(credit_ret), .wr_done(wr_done)
	);

	mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_wdata(wr_wdata), .wr_be(wr_be),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_be(host_be), .mem_rdata(mem_rdata),
		.fetch_gnt(fetch_gnt), .wr_gnt(wr_gnt), .host_gnt(host_gnt),
		.fetch_rvalid(fetch_rvalid), .host_rvalid(host_rvalid), .rdata(rdata),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_be(mem_be)
	);

	phrase_ram #(.ADDR_W(ADDR_W)) u_ram (
		.sys_clk(sys_clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_be(mem_be), .mem_rdata(mem_rdata)
	);

	// Host sees the shared read bus
	assign host_rdata = rdata;

endmodule

/* source/comp_ctrl.sv */
// Phrase-mode write inhibit
module comp_ctrl import blit_pkg::*; (
	input logic sys_clk,
	input logic rst_n,
	input logic in_valid,
	input phrase_t in_data,
	input byte_mask_t dcomp,
	input pix_size_t pixsize,
	input logic dcompen,
	input logic bcompen,
	input phrase_t fgcolor,
	output logic out_valid,
	output phrase_t out_data,
	output byte_mask_t dbinh_n
);

	logic cmp8;
	logic cmp16;
	byte_mask_t inhibit;

	// Data compare only in the two supported pixel sizes
	assign cmp8 = dcompen && (pixsize == PIX_8BPP);
	assign cmp16 = dcompen && (pixsize == PIX_16BPP);

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			// Monochrome expansion, source low byte selects bytes
			inhibit[i] = bcompen && !in_data[i];
			// Transparent byte
			if (cmp8 && dcomp[i]) begin
				inhibit[i] = 1'b1;
			end
			// Transparent pixel needs both bytes of the pair
			if (cmp16 && dcomp[i & ~1] && dcomp[i | 1]) begin
				inhibit[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Foreground colour replaces source data in bit compare mode
	always_ff @(posedge sys_clk) begin
		out_data <= bcompen ? fgcolor : in_data;
		dbinh_n <= ~inhibit;
	end

endmodule

/* source/data_compare.sv */
// Byte-wise pattern compare
module data_compare import blit_pkg::*; (
	input logic sys_clk,
	input logic rst_n,
	input logic in_valid,
	input phrase_t in_data,
	input logic [7:0] pattern,
	output logic out_valid,
	output phrase_t out_data,
	output byte_mask_t dcomp
);

	byte_mask_t eq;

	// One equality flag per source byte
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			eq[i] = (in_data[8*i +: 8] == pattern);
		end
	end

	// Valid stage
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Data and compare result travel with the valid
	always_ff @(posedge sys_clk) begin
		out_data <= in_data;
		dcomp <= eq;
	end

endmodule

/* source/dst_writer.sv */
// Destination write buffer
module dst_writer import blit_pkg::*; #(
	parameter int ADDR_W = 10,
	parameter int BUF_DEPTH = 2
) (
	input logic sys_clk,
	input logic rst_n,
	input logic run,
	input logic [ADDR_W-1:0] dst_base,
	input logic in_valid,
	input phrase_t in_data,
	input byte_mask_t dbinh_n,
	input logic gnt,
	output logic req,
	output logic [ADDR_W-1:0] addr,
	output phrase_t wdata,
	output byte_mask_t be,
	output logic credit_ret,
	output logic wr_done
);

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int FILL_W = $clog2(BUF_DEPTH + 1);

	phrase_t buf_data [BUF_DEPTH];
	byte_mask_t buf_mask [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [FILL_W-1:0] fill;
	logic [ADDR_W-1:0] wr_idx;
	logic pop;

	// Head entry drives the write
	assign req = (fill != '0);
	assign addr = dst_base + wr_idx;
	assign wdata = buf_data[rd_ptr];
	// Inhibited bytes are simply not enabled
	assign be = buf_mask[rd_ptr];
	assign pop = req && gnt;

	// Each write frees a slot and completes a phrase
	assign credit_ret = pop;
	assign wr_done = pop;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
			// Credits keep the push side from overrunning
			fill <= fill + FILL_W'(in_valid) - FILL_W'(pop);
		end
	end

	// Destination index restarts with each blit
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_idx <= '0;
		end else if (!run) begin
			wr_idx <= '0;
		end else if (pop) begin
			wr_idx <= wr_idx + ADDR_W'(1);
		end
	end

	// Slot storage
	always_ff @(posedge sys_clk) begin
		if (in_valid) begin
			buf_data[wr_ptr] <= in_data;
			buf_mask[wr_ptr] <= dbinh_n;
		end
	end

endmodule

/* source/mem_arbiter.sv */
// Round-robin memory arbiter
module mem_arbiter import blit_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input logic sys_clk,
	input logic rst_n,
	input logic fetch_req,
	input logic [ADDR_W-1:0] fetch_addr,
	input logic wr_req,
	input logic [ADDR_W-1:0] wr_addr,
	input phrase_t wr_wdata,
	input byte_mask_t wr_be,
	input logic host_req,
	input logic host_we,
	input logic [ADDR_W-1:0] host_addr,
	input phrase_t host_wdata,
	input byte_mask_t host_be,
	input phrase_t mem_rdata,
	output logic fetch_gnt,
	output logic wr_gnt,
	output logic host_gnt,
	output logic fetch_rvalid,
	output logic host_rvalid,
	output phrase_t rdata,
	output logic mem_en,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_addr,
	output phrase_t mem_wdata,
	output byte_mask_t mem_be
);

	logic [2:0] req_vec;
	logic gnt_valid;
	arb_sel_t gnt_sel;
	arb_sel_t last_sel;
	arb_sel_t rd_owner;
	logic rd_pending;

	assign req_vec = {host_req, wr_req, fetch_req};

	// Search starts one past the last winner
	always_comb begin
		int idx;
		gnt_valid = 1'b0;
		gnt_sel = last_sel;
		for (int k = 1; k <= 3; k++) begin
			idx = (int'(last_sel) + k) % 3;
			if (!gnt_valid && req_vec[idx]) begin
				gnt_valid = 1'b1;
				gnt_sel = arb_sel_t'(idx);
			end
		end
	end

	assign fetch_gnt = gnt_valid && (gnt_sel == SEL_FETCH);
	assign wr_gnt = gnt_valid && (gnt_sel == SEL_WRITER);
	assign host_gnt = gnt_valid && (gnt_sel == SEL_HOST);

	// Memory port mux
	always_comb begin
		mem_en = gnt_valid;
		case (gnt_sel)
			SEL_FETCH: begin
				mem_we = 1'b0;
				mem_addr = fetch_addr;
				mem_wdata = wr_wdata;
				mem_be = '1;
			end
			SEL_WRITER: begin
				mem_we = 1'b1;
				mem_addr = wr_addr;
				mem_wdata = wr_wdata;
				mem_be = wr_be;
			end
			default: begin
				mem_we = host_we;
				mem_addr = host_addr;
				mem_wdata = host_wdata;
				mem_be = host_be;
			end
		endcase
	end

	// Winner pointer and owner of the read in flight
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			last_sel <= SEL_HOST;
			rd_owner <= SEL_FETCH;
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= gnt_valid && !mem_we;
			if (gnt_valid) begin
				last_sel <= gnt_sel;
				rd_owner <= gnt_sel;
			end
		end
	end

	// Read data is shared, the valid goes to the issuer only
	assign rdata = mem_rdata;
	assign fetch_rvalid = rd_pending && (rd_owner == SEL_FETCH);
	assign host_rvalid = rd_pending && (rd_owner == SEL_HOST);

endmodule

/* source/phrase_ram.sv */
// Single-port phrase memory
module phrase_ram import blit_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input logic sys_clk,
	input logic mem_en,
	input logic mem_we,
	input logic [ADDR_W-1:0] mem_addr,
	input phrase_t mem_wdata,
	input byte_mask_t mem_be,
	output phrase_t mem_rdata
);

	phrase_t mem [2**ADDR_W];

	always_ff @(posedge sys_clk) begin
		if (mem_en) begin
			if (mem_we) begin
				// Byte-enabled write
				for (int i = 0; i < 8; i++) begin
					if (mem_be[i]) begin
						mem[mem_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
					end
				end
			end else begin
				// Read data one cycle after the grant
				mem_rdata <= mem[mem_addr];
			end
		end
	end

endmodule

/* source/src_fetch.sv */
// Source phrase fetch unit
module src_fetch #(
	parameter int ADDR_W = 10,
	parameter int CNT_W = 8,
	parameter int BUF_DEPTH = 2
) (
	input logic sys_clk,
	input logic rst_n,
	input logic run,
	input logic [ADDR_W-1:0] src_base,
	input logic [CNT_W-1:0] count,
	input logic credit_ret,
	input logic gnt,
	output logic req,
	output logic [ADDR_W-1:0] addr
);

	localparam int CRED_W = $clog2(BUF_DEPTH + 1);

	logic [CRED_W-1:0] credits;
	logic [CNT_W-1:0] rd_idx;
	logic take;

	// Read only with a free writer slot and phrases left
	assign req = run && (credits != '0) && (rd_idx != count);
	assign addr = src_base + ADDR_W'(rd_idx);
	assign take = req && gnt;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CRED_W'(BUF_DEPTH);
			rd_idx <= '0;
		end else if (!run) begin
			// Fresh credits for the next blit
			credits <= CRED_W'(BUF_DEPTH);
			rd_idx <= '0;
		end else begin
			rd_idx <= rd_idx + CNT_W'(take);
			// Spend on grant, regain on each buffered write
			credits <= credits + CRED_W'(credit_ret) - CRED_W'(take);
		end
	end

endmodule

/* sources.f */
+incdir+sim
source/blit_pkg.sv
source/blit_ctrl.sv
source/src_fetch.sv
source/data_compare.sv
source/comp_ctrl.sv
source/dst_writer.sv
source/mem_arbiter.sv
source/phrase_ram.sv
source/blit_top.sv
sim/tb_blit.sv
